/* include/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath and instruction width
`define XLEN 32

// register file geometry
`define REG_ADDR_W 5
`define NUM_REGS 32

// instruction field widths
`define OPC_W 7
`define F3_W 3
`define F7_W 7

// major opcodes, RV32I encoding
`define OPC_OP 7'b0110011
`define OPC_OP_IMM 7'b0010011

// funct3 codes shared by both forms
`define F3_ADD 3'b000
`define F3_SLT 3'b010
`define F3_XOR 3'b100
`define F3_OR 3'b110
`define F3_AND 3'b111

// funct7 codes, register-register form only
`define F7_BASE 7'b0000000
`define F7_SUB 7'b0100000

// width of the I-type immediate field
`define IMM_I_W 12

`endif

/* rtl/rv_pkg.sv */
`include "rv_defines.svh"

package rv_pkg;

	// operation carried from decode to the ALU
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_t;

	// instruction word as it enters the core
	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] instr;
	} fetch_rec_t;

	// decoded instruction with its operands read
	typedef struct packed {
		logic valid;
		alu_op_t alu_op;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		// b holds the immediate when set
		logic use_imm;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
	} ex_rec_t;

	// writeback record, also what the core retires
	typedef struct packed {
		logic valid;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0] data;
		logic overflow;
	} wb_rec_t;

endpackage

/* rtl/rv_alu.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_alu (
	input rv_pkg::alu_op_t op,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] result,
	output logic overflow
);

	logic [`XLEN-1:0] sum;
	logic [`XLEN-1:0] diff;
	logic add_ovf;
	logic sub_ovf;
	logic less;

	assign sum = a + b;
	assign diff = a - b;

	// same signs in, different sign out
	assign add_ovf = (a[`XLEN-1] == b[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);
	// signs differ and result flips away from a
	assign sub_ovf = (a[`XLEN-1] != b[`XLEN-1]) && (diff[`XLEN-1] != a[`XLEN-1]);

	assign less = $signed(a) < $signed(b);

	always_comb begin
		result = sum;
		overflow = 1'b0;
		case (op)
			rv_pkg::alu_add: begin
				result = sum;
				overflow = add_ovf;
			end
			rv_pkg::alu_sub: begin
				result = diff;
				overflow = sub_ovf;
			end
			rv_pkg::alu_and: result = a & b;
			rv_pkg::alu_or: result = a | b;
			rv_pkg::alu_xor: result = a ^ b;
			rv_pkg::alu_slt: result = {{(`XLEN-1){1'b0}}, less};
			default: result = sum;
		endcase
	end

endmodule

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_regfile (
	input logic clock,
	input logic reset,
	input logic [`REG_ADDR_W-1:0] rd_addr_a,
	input logic [`REG_ADDR_W-1:0] rd_addr_b,
	input rv_pkg::wb_rec_t wr,
	output logic [`XLEN-1:0] rd_data_a,
	output logic [`XLEN-1:0] rd_data_b
);

	logic [`XLEN-1:0] regs [`NUM_REGS];

	// x0 never written
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid && wr.rd != '0) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// x0 reads zero, a pending write passes straight through
	always_comb begin
		if (rd_addr_a == '0) begin
			rd_data_a = '0;
		end else if (wr.valid && wr.rd == rd_addr_a) begin
			rd_data_a = wr.data;
		end else begin
			rd_data_a = regs[rd_addr_a];
		end
	end

	always_comb begin
		if (rd_addr_b == '0) begin
			rd_data_b = '0;
		end else if (wr.valid && wr.rd == rd_addr_b) begin
			rd_data_b = wr.data;
		end else begin
			rd_data_b = regs[rd_addr_b];
		end
	end

endmodule

/* rtl/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decode (
	input logic clock,
	input logic reset,
	input rv_pkg::fetch_rec_t fetch,
	input logic [`XLEN-1:0] rd_data_a,
	input logic [`XLEN-1:0] rd_data_b,
	output logic [`REG_ADDR_W-1:0] rd_addr_a,
	output logic [`REG_ADDR_W-1:0] rd_addr_b,
	output rv_pkg::ex_rec_t ex
);

	rv_pkg::fetch_rec_t fetch_q;
	rv_pkg::ex_rec_t ex_d;
	rv_pkg::ex_rec_t ex_q;
	rv_pkg::alu_op_t alu_op;
	logic [`OPC_W-1:0] opcode;
	logic [`REG_ADDR_W-1:0] rd;
	logic [`REG_ADDR_W-1:0] rs1;
	logic [`REG_ADDR_W-1:0] rs2;
	logic [`F3_W-1:0] funct3;
	logic [`F7_W-1:0] funct7;
	logic [`XLEN-1:0] imm_i;
	logic is_op;
	logic is_op_imm;
	logic funct_ok;

	// fetch register, every valid input is taken
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			fetch_q <= '0;
		end else begin
			fetch_q <= fetch;
		end
	end

	// instruction fields
	assign opcode = fetch_q.instr[`OPC_W-1:0];
	assign rd = fetch_q.instr[11:7];
	assign funct3 = fetch_q.instr[14:12];
	assign rs1 = fetch_q.instr[19:15];
	assign rs2 = fetch_q.instr[24:20];
	assign funct7 = fetch_q.instr[31:25];

	// I-type immediate, sign extended from bit 31
	assign imm_i = {{(`XLEN-`IMM_I_W){fetch_q.instr[31]}}, fetch_q.instr[31:20]};

	assign is_op = (opcode == `OPC_OP);
	assign is_op_imm = (opcode == `OPC_OP_IMM);

	// register read happens in this cycle
	assign rd_addr_a = rs1;
	assign rd_addr_b = rs2;

	// funct codes to ALU operation
	always_comb begin
		alu_op = rv_pkg::alu_add;
		funct_ok = 1'b1;
		case (funct3)
			`F3_ADD: begin
				// sub only exists in the register form
				if (is_op && funct7 == `F7_SUB) begin
					alu_op = rv_pkg::alu_sub;
				end
			end
			`F3_SLT: alu_op = rv_pkg::alu_slt;
			`F3_XOR: alu_op = rv_pkg::alu_xor;
			`F3_OR: alu_op = rv_pkg::alu_or;
			`F3_AND: alu_op = rv_pkg::alu_and;
			default: funct_ok = 1'b0;
		endcase
		// register form takes funct7 zero, or the sub code on add
		if (is_op && funct7 != `F7_BASE) begin
			if (funct7 != `F7_SUB || funct3 != `F3_ADD) begin
				funct_ok = 1'b0;
			end
		end
	end

	// execute record, anything unsupported becomes a bubble
	always_comb begin
		ex_d.valid = fetch_q.valid && (is_op || is_op_imm) && funct_ok;
		ex_d.alu_op = alu_op;
		ex_d.rd = rd;
		ex_d.rs1 = rs1;
		ex_d.rs2 = rs2;
		ex_d.use_imm = is_op_imm;
		ex_d.a = rd_data_a;
		ex_d.b = is_op_imm ? imm_i : rd_data_b;
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_q <= '0;
		end else begin
			ex_q <= ex_d;
		end
	end

	assign ex = ex_q;

endmodule

/* rtl/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_execute (
	input logic clock,
	input logic reset,
	input rv_pkg::ex_rec_t ex,
	input rv_pkg::wb_rec_t wb_fwd,
	output rv_pkg::wb_rec_t wb
);

	rv_pkg::wb_rec_t wb_d;
	rv_pkg::wb_rec_t wb_q;
	logic fwd_live;
	logic fwd_a;
	logic fwd_b;
	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] alu_result;
	logic alu_overflow;

	// wb holds the only result not yet in the register file
	assign fwd_live = wb_fwd.valid && (wb_fwd.rd != '0);
	assign fwd_a = fwd_live && (wb_fwd.rd == ex.rs1);

	// immediate operand never takes the bypass
	assign fwd_b = fwd_live && !ex.use_imm && (wb_fwd.rd == ex.rs2);

	assign op_a = fwd_a ? wb_fwd.data : ex.a;
	assign op_b = fwd_b ? wb_fwd.data : ex.b;

	rv_alu rv_alu_inst (
		.op(ex.alu_op),
		.a(op_a),
		.b(op_b),
		.result(alu_result),
		.overflow(alu_overflow)
	);

	always_comb begin
		wb_d.valid = ex.valid;
		wb_d.rd = ex.rd;
		wb_d.data = alu_result;
		wb_d.overflow = alu_overflow;
	end

	// writeback record, one per valid ex record
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb_q <= '0;
		end else begin
			wb_q <= wb_d;
		end
	end

	assign wb = wb_q;

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core (
	input logic clock,
	input logic reset,
	input rv_pkg::fetch_rec_t fetch,
	output rv_pkg::wb_rec_t retire
);

	logic [`REG_ADDR_W-1:0] rd_addr_a;
	logic [`REG_ADDR_W-1:0] rd_addr_b;
	logic [`XLEN-1:0] rd_data_a;
	logic [`XLEN-1:0] rd_data_b;
	rv_pkg::ex_rec_t ex;
	rv_pkg::wb_rec_t wb;

	// fetch register, decode and operand read
	rv_decode rv_decode_inst (
		.clock(clock),
		.reset(reset),
		.fetch(fetch),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.ex(ex)
	);

	// written from the wb record one edge after it is valid
	rv_regfile rv_regfile_inst (
		.clock(clock),
		.reset(reset),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.wr(wb),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b)
	);

	// wb loops back for operand bypass
	rv_execute rv_execute_inst (
		.clock(clock),
		.reset(reset),
		.ex(ex),
		.wb_fwd(wb),
		.wb(wb)
	);

	assign retire = wb;

endmodule

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_rv_core;

	typedef struct {
		rv_pkg::wb_rec_t rec;
		int due;
	} expect_t;

	localparam int reset_limit = 10;
	localparam int drain_limit = 40;
	localparam int random_count = 400;

	logic clock;
	logic reset;
	rv_pkg::fetch_rec_t fetch;
	rv_pkg::wb_rec_t retire;

	expect_t exp_q[$];
	logic [`XLEN-1:0] shadow [`NUM_REGS];
	logic [31:0] lcg_state;
	int cycle;
	int issued;
	int retired;

	rv_core rv_core_inst (
		.clock(clock),
		.reset(reset),
		.fetch(fetch),
		.retire(retire)
	);

	always #5 clock = ~clock;

	// edge counter, read by stimulus before its own update
	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [`XLEN-1:0] encode_r(input logic [`F7_W-1:0] f7,
			input logic [`F3_W-1:0] f3, input logic [`REG_ADDR_W-1:0] rd,
			input logic [`REG_ADDR_W-1:0] rs1, input logic [`REG_ADDR_W-1:0] rs2);
		return {f7, rs2, rs1, f3, rd, `OPC_OP};
	endfunction

	function automatic logic [`XLEN-1:0] encode_i(input logic [`OPC_W-1:0] opc,
			input logic [`F3_W-1:0] f3, input logic [`REG_ADDR_W-1:0] rd,
			input logic [`REG_ADDR_W-1:0] rs1, input logic [`IMM_I_W-1:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic is_supported(input logic [`XLEN-1:0] instr);
		logic [`F3_W-1:0] f3;
		logic [`F7_W-1:0] f7;
		logic f3_known;
		f3 = instr[14:12];
		f7 = instr[31:25];
		f3_known = (f3 == `F3_ADD) || (f3 == `F3_SLT) || (f3 == `F3_XOR) ||
			(f3 == `F3_OR) || (f3 == `F3_AND);
		if (instr[6:0] == `OPC_OP_IMM) begin
			return f3_known;
		end
		if (instr[6:0] == `OPC_OP) begin
			return (f7 == `F7_BASE && f3_known) || (f7 == `F7_SUB && f3 == `F3_ADD);
		end
		return 1'b0;
	endfunction

	// expected retire record from the shadow register file
	function automatic rv_pkg::wb_rec_t model_instr(input logic [`XLEN-1:0] instr);
		rv_pkg::wb_rec_t rec;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic is_imm;
		longint exact;
		is_imm = (instr[6:0] == `OPC_OP_IMM);
		a = shadow[instr[19:15]];
		b = is_imm ? 32'($signed(instr[31:20])) : shadow[instr[24:20]];
		rec = '0;
		rec.valid = 1'b1;
		rec.rd = instr[11:7];
		case (instr[14:12])
			`F3_ADD: begin
				if (!is_imm && instr[31:25] == `F7_SUB) begin
					rec.data = a - b;
					exact = longint'($signed(a)) - longint'($signed(b));
				end else begin
					rec.data = a + b;
					exact = longint'($signed(a)) + longint'($signed(b));
				end
				// exact sum no longer fits in 32 bits
				rec.overflow = (exact != longint'($signed(rec.data)));
			end
			`F3_SLT: rec.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			`F3_XOR: rec.data = a ^ b;
			`F3_OR: rec.data = a | b;
			default: rec.data = a & b;
		endcase
		return rec;
	endfunction

	task automatic stop_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_retire_data(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
		if (got !== exp) begin
			$display("FAIL at %0t: retire data %h, expected %h", $time, got, exp);
			stop_run();
		end
	endtask

	task automatic check_retire_rd(input logic [`REG_ADDR_W-1:0] got,
			input logic [`REG_ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("FAIL at %0t: retire rd x%0d, expected x%0d", $time, got, exp);
			stop_run();
		end
	endtask

	task automatic check_retire_overflow(input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL at %0t: retire overflow %b, expected %b", $time, got, exp);
			stop_run();
		end
	endtask

	// compare at the falling edge where retire is stable
	always @(negedge clock) begin : compare
		expect_t head;
		if (reset === 1'b1) begin
			if (retire.valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("retire at %0t with no instruction outstanding", $time);
					stop_run();
				end else begin
					head = exp_q.pop_front();
					if (head.due != cycle) begin
						$display("retire in cycle %0d, it was due in cycle %0d", cycle, head.due);
						stop_run();
					end else begin
						check_retire_rd(retire.rd, head.rec.rd);
						check_retire_data(retire.data, head.rec.data);
						check_retire_overflow(retire.overflow, head.rec.overflow);
						retired++;
					end
				end
			end else if (exp_q.size() > 0 && exp_q[0].due <= cycle) begin
				$display("no retire in cycle %0d for an instruction due then", cycle);
				stop_run();
			end
		end
	end

	task automatic send_instr(input logic valid, input logic [`XLEN-1:0] instr);
		rv_pkg::wb_rec_t rec;
		expect_t item;
		@(posedge clock);
		fetch.valid <= valid;
		fetch.instr <= instr;
		if (valid && is_supported(instr)) begin
			rec = model_instr(instr);
			if (rec.rd != '0) begin
				shadow[rec.rd] = rec.data;
			end
			item.rec = rec;
			// this drive edge is cycle + 1, retire three edges later
			item.due = cycle + 1 + 3;
			exp_q.push_back(item);
			issued++;
		end
	endtask

	task automatic send_random();
		logic [31:0] r;
		logic [31:0] s;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`F3_W-1:0] f3;
		logic [`F7_W-1:0] f7;
		r = next_rand();
		s = next_rand();
		// small register range keeps dependencies dense
		rd = {2'b00, r[23:21]};
		rs1 = r[20] ? r[19:15] : {2'b00, r[14:12]};
		case (s[19:17] % 5)
			0: f3 = `F3_ADD;
			1: f3 = `F3_SLT;
			2: f3 = `F3_XOR;
			3: f3 = `F3_OR;
			default: f3 = `F3_AND;
		endcase
		f7 = (f3 == `F3_ADD && s[16]) ? `F7_SUB : `F7_BASE;
		if (r[31:24] < 24) begin
			send_instr(1'b0, s);
		end else if (r[31:24] < 40) begin
			case (s[15:14])
				0: send_instr(1'b1, encode_i(7'b0000011, 3'b010, rd, rs1, s[31:20]));
				1: send_instr(1'b1, encode_i(`OPC_OP_IMM, 3'b001, rd, rs1, s[31:20]));
				default: send_instr(1'b1, encode_r(7'b0000001, f3, rd, rs1, s[29:25]));
			endcase
		end else if (r[31:24] < 150) begin
			send_instr(1'b1, encode_r(f7, f3, rd, rs1, {2'b00, s[31:29]}));
		end else begin
			send_instr(1'b1, encode_i(`OPC_OP_IMM, f3, rd, rs1, s[31:20]));
		end
	endtask

	initial begin : main
		int wait_count;
		clock = 1'b0;
		reset = 1'b0;
		fetch = '0;
		cycle = 0;
		issued = 0;
		retired = 0;
		lcg_state = 32'd2;
		for (int i = 0; i < `NUM_REGS; i++) begin
			shadow[i] = '0;
		end
		repeat (2) @(posedge clock);
		reset <= 1'b1;
		wait_count = 0;
		while (!(reset === 1'b1 && retire.valid === 1'b0)) begin
			@(posedge clock);
			wait_count++;
			if (wait_count > reset_limit) begin
				$display("pipeline did not come out of reset");
				stop_run();
			end
		end

		// idle, then reads of never written registers
		repeat (3) send_instr(1'b0, '0);
		send_instr(1'b1, encode_r(`F7_BASE, `F3_ADD, 5, 20, 21));
		send_instr(1'b1, encode_r(`F7_BASE, `F3_OR, 6, 31, 30));
		send_instr(1'b1, encode_i(`OPC_OP_IMM, `F3_SLT, 7, 25, 12'hfff));

		// doubling chain through the bypass up to the most negative value
		send_instr(1'b1, encode_i(`OPC_OP_IMM, `F3_ADD, 1, 0, 12'd1));
		repeat (31) send_instr(1'b1, encode_r(`F7_BASE, `F3_ADD, 1, 1, 1));
		send_instr(1'b1, encode_r(`F7_SUB, `F3_ADD, 2, 0, 1));
		send_instr(1'b1, encode_i(`OPC_OP_IMM, `F3_ADD, 3, 1, 12'hfff));
		send_instr(1'b1, encode_r(`F7_BASE, `F3_SLT, 4, 1, 3));
		send_instr(1'b1, encode_i(`OPC_OP_IMM, `F3_SLT, 4, 3, 12'hffb));
		send_instr(1'b1, encode_r(`F7_SUB, `F3_ADD, 2, 3, 1));
		send_instr(1'b1, encode_i(`OPC_OP_IMM, `F3_XOR, 8, 1, 12'h800));
		send_instr(1'b1, encode_i(`OPC_OP_IMM, `F3_AND, 9, 3, 12'h7ff));

		// x0 write retires but reads back zero
		send_instr(1'b1, encode_i(`OPC_OP_IMM, `F3_ADD, 0, 1, 12'd5));
		send_instr(1'b1, encode_r(`F7_BASE, `F3_ADD, 10, 0, 0));
		send_instr(1'b1, encode_r(7'b0000001, `F3_ADD, 11, 1, 1));
		send_instr(1'b1, encode_i(`OPC_OP_IMM, 3'b001, 12, 1, 12'd3));

		repeat (random_count) send_random();

		wait_count = 0;
		while (exp_q.size() != 0) begin
			send_instr(1'b0, '0);
			wait_count++;
			if (wait_count > drain_limit) begin
				$display("pipeline did not drain, %0d retires still missing", exp_q.size());
				stop_run();
			end
		end
		// quiet tail, any extra retire fails in the compare process
		repeat (5) send_instr(1'b0, '0);

		if (retired == issued && issued > 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("retired %0d of %0d issued instructions", retired, issued);
			stop_run();
		end
	end

endmodule

/* rv_lite.f */
+incdir+include
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_core.sv
tb/tb_rv_core.sv
